/* Makefile */
TOP = cpuTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/cpuTb.sv */
`default_nettype none
`include "cpu_consts.svh"

module cpuTb
    import cpuPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Bit i set when branch i (BRA..BVS) is taken
    localparam logic [8:0] TakenNegOvf  = 9'b101001011;  // After 7F + 01: n v set
    localparam logic [8:0] TakenZeroCry = 9'b010110101;  // After FF + 01: z c set

    logic  clk;
    logic  reset;
    wbReqT wbOut;
    wbRspT wbIn;

    dataT  code [$];
    addrT  presetAddr [$];
    dataT  presetData [$];
    addrT  expAddr [$];
    dataT  expData [$];
    string testName;
    string caseName;
    int    testErrors;
    int    errorCount;
    int    testCount;
    int    failedTests;

    cpuTop dut (.clk(clk), .reset(reset), .wbOut(wbOut), .wbIn(wbIn));

    wbMemModel #(.Seed(32'h047f_fa18)) memory (.clk(clk), .req(wbOut), .rsp(wbIn));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkData(input string name, input dataT got, input dataT exp);
        if (got !== exp) begin
            $display("FAIL %s %s: got 0x%h, expected 0x%h", caseName, name, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkAddr(input string name, input addrT got, input addrT exp);
        if (got !== exp) begin
            $display("FAIL %s %s: got 0x%h, expected 0x%h", caseName, name, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s %s: got 0x%h, expected 0x%h", caseName, name, got, exp);
            testErrors++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("%s: %s", caseName, msg);
        testErrors++;
    endtask

    task automatic emit2(input dataT op, input dataT arg);
        code.push_back(op);
        code.push_back(arg);
    endtask

    task automatic emit3(input dataT op, input dataT arg1, input dataT arg2);
        code.push_back(op);
        code.push_back(arg1);
        code.push_back(arg2);
    endtask

    // Offset counts from the byte after the offset itself
    task automatic emitBranchTo(input dataT op, input addrT target);
        addrT afterOffset;
        afterOffset = addrT'(code.size() + 2);
        emit2(op, dataT'(target - afterOffset));
    endtask

    task automatic emitHalt();
        emitBranchTo(`OP_BRA, addrT'(code.size()));  // Branch to itself
    endtask

    task automatic newProgram(input string name);
        caseName = name;
        code.delete();
        presetAddr.delete();
        presetData.delete();
        expAddr.delete();
        expData.delete();
    endtask

    task automatic presetByte(input addrT adr, input dataT value);
        presetAddr.push_back(adr);
        presetData.push_back(value);
    endtask

    task automatic expectWrite(input addrT adr, input dataT value);
        expAddr.push_back(adr);
        expData.push_back(value);
    endtask

    // Core stays in reset while memory is filled
    task automatic startProgram();
        @(negedge clk);
        reset = 1'b0;
        for (int a = 0; a < 256; a++) begin
            memory.bytes[a] = dataT'(a) ^ 8'h5C;
        end
        foreach (code[i]) begin
            memory.bytes[i] = code[i];
        end
        foreach (presetAddr[i]) begin
            memory.bytes[presetAddr[i]] = presetData[i];
        end
        memory.logAddr.delete();
        memory.logData.delete();
        repeat (8) begin
            @(negedge clk);
            checkBit("wbOut.cyc", wbOut.cyc, 1'b0);
            checkBit("wbOut.stb", wbOut.stb, 1'b0);
        end
        reset = 1'b1;
    endtask

    task automatic waitWrites(input int count);
        int cycles;
        cycles = 0;
        while (memory.logAddr.size() < count && cycles < 3000) begin
            @(negedge clk);
            cycles++;
        end
        if (memory.logAddr.size() < count) begin
            reportProblem($sformatf("timed out with %0d of %0d writes seen",
                memory.logAddr.size(), count));
        end
    endtask

    task automatic captureCycle(output addrT adr, output logic we);
        int cycles;
        cycles = 0;
        while (!(wbOut.cyc && wbOut.stb) && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!(wbOut.cyc && wbOut.stb)) begin
            reportProblem("no bus cycle started in time");
        end
        adr    = wbOut.adr;
        we     = wbOut.we;
        cycles = 0;
        while (wbOut.cyc && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (wbOut.cyc) begin
            reportProblem("bus cycle was never acknowledged");
        end
    endtask

    task automatic compareWrites();
        if (memory.logAddr.size() != expAddr.size()) begin
            reportProblem($sformatf("memory logged %0d writes where %0d were expected",
                memory.logAddr.size(), expAddr.size()));
        end
        for (int i = 0; i < expAddr.size() && i < memory.logAddr.size(); i++) begin
            checkAddr($sformatf("write %0d wbOut.adr", i), memory.logAddr[i], expAddr[i]);
            checkData($sformatf("write %0d wbOut.datOut", i), memory.logData[i], expData[i]);
        end
    endtask

    task automatic finishProgram();
        waitWrites(expAddr.size());
        repeat (40) @(negedge clk);  // Window for any stray write
        compareWrites();
    endtask

    task automatic runProgram();
        startProgram();
        finishProgram();
    endtask

    task automatic beginTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        testCount++;
        errorCount += testErrors;
        if (testErrors == 0) begin
            $display("Test %s: ok", testName);
        end else begin
            failedTests++;
            $display("Test %s: %0d errors", testName, testErrors);
        end
    endtask

    task automatic buildLoadStore();
        newProgram("load and store");
        emit3(`OP_LDI, 8'h05, 8'h3C);
        emit3(`OP_LDI, 8'h09, 8'hA7);
        emit3(`OP_LDI, 8'h0F, 8'h81);
        emit3(`OP_STD, 8'h05, 8'h40);
        emit3(`OP_STD, 8'h09, 8'h41);
        emit3(`OP_STD, 8'h0F, 8'hFE);
        emitHalt();
        expectWrite(8'h40, 8'h3C);
        expectWrite(8'h41, 8'hA7);
        expectWrite(8'hFE, 8'h81);
    endtask

    task automatic buildAluOps();
        dataT a;
        dataT b;
        dataT ops [5];
        dataT results [5];
        a       = 8'hC5;
        b       = 8'h5A;
        ops     = '{`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR};
        results = '{dataT'(a + b), dataT'(a - b), a & b, a | b, a ^ b};
        newProgram("alu ops");
        emit3(`OP_LDI, 8'h02, b);
        for (int i = 0; i < 5; i++) begin
            emit3(`OP_LDI, 8'h01, a);  // Fresh first operand each time
            emit3(ops[i], 8'h01, 8'h02);
            emit3(`OP_STD, 8'h01, dataT'(8'h60 + i));
            expectWrite(addrT'(8'h60 + i), results[i]);
        end
        emit3(`OP_LDI, 8'h03, 8'hFF);
        emit2(`OP_INC, 8'h03);
        emit3(`OP_STD, 8'h03, 8'h65);
        emit3(`OP_LDI, 8'h04, 8'h00);
        emit2(`OP_DEC, 8'h04);
        emit3(`OP_STD, 8'h04, 8'h66);
        emitHalt();
        expectWrite(8'h65, 8'h00);  // Wraps up
        expectWrite(8'h66, 8'hFF);  // Wraps down
    endtask

    task automatic buildLoadDirect();
        newProgram("load direct");
        presetByte(8'hC8, 8'h6D);
        presetByte(8'h99, 8'hE2);
        emit3(`OP_LDD, 8'h07, 8'hC8);
        emit3(`OP_LDD, 8'h00, 8'h99);
        emit3(`OP_STD, 8'h07, 8'hD0);
        emit3(`OP_STD, 8'h00, 8'h9A);
        emitHalt();
        expectWrite(8'hD0, 8'h6D);
        expectWrite(8'h9A, 8'hE2);
    endtask

    // Taken path stores to E1, fall-through to E0, both end at EF
    task automatic runBranchCase(input dataT op, input dataT a, input logic taken);
        newProgram($sformatf("branch %h after %h+01", op, a));
        emit3(`OP_LDI, 8'h01, a);
        emit3(`OP_LDI, 8'h02, 8'h01);
        emit3(`OP_ADD, 8'h01, 8'h02);
        emitBranchTo(op, addrT'(code.size() + 7));
        emit3(`OP_STD, 8'h02, 8'hE0);
        emitBranchTo(`OP_BRA, addrT'(code.size() + 5));
        emit3(`OP_STD, 8'h02, 8'hE1);
        emit3(`OP_STD, 8'h02, 8'hEF);
        emitHalt();
        expectWrite(taken ? 8'hE1 : 8'hE0, 8'h01);
        expectWrite(8'hEF, 8'h01);
        runProgram();
    endtask

    task automatic testResetAndNop();
        addrT adr;
        logic we;
        beginTest("reset and no-op");
        newProgram("reset");
        code.push_back(8'h00);  // Undefined opcode
        emit3(`OP_LDI, 8'h01, 8'h5A);
        emit3(`OP_STD, 8'h01, 8'hF0);
        emitHalt();
        expectWrite(8'hF0, 8'h5A);
        startProgram();
        captureCycle(adr, we);
        checkAddr("first wbOut.adr", adr, `RESET_PC);
        checkBit("first wbOut.we", we, 1'b0);
        captureCycle(adr, we);
        checkAddr("second wbOut.adr", adr, 8'h01);
        checkBit("second wbOut.we", we, 1'b0);
        finishProgram();
        endTest();
    endtask

    task automatic testBranches();
        dataT ops [9];
        addrT loopTop;
        ops = '{`OP_BRA, `OP_BCC, `OP_BCS, `OP_BNE, `OP_BEQ,
                `OP_BPL, `OP_BMI, `OP_BVC, `OP_BVS};
        beginTest("branches");
        for (int i = 0; i < 9; i++) begin
            runBranchCase(ops[i], 8'h7F, TakenNegOvf[i]);
            runBranchCase(ops[i], 8'hFF, TakenZeroCry[i]);
        end
        newProgram("countdown loop");
        emit3(`OP_LDI, 8'h01, 8'h03);
        loopTop = addrT'(code.size());
        emit2(`OP_DEC, 8'h01);
        emit3(`OP_STD, 8'h01, 8'hE3);
        emitBranchTo(`OP_BNE, loopTop);  // Negative offset
        emitHalt();
        for (int n = 2; n >= 0; n--) begin
            expectWrite(8'hE3, dataT'(n));
        end
        runProgram();
        endTest();
    endtask

    initial begin
        reset       = 1'b0;
        testCount   = 0;
        errorCount  = 0;
        failedTests = 0;
        testResetAndNop();
        beginTest("load immediate and store");
        buildLoadStore();
        runProgram();
        endTest();
        beginTest("alu operations");
        buildAluOps();
        runProgram();
        endTest();
        beginTest("load direct and store");
        buildLoadDirect();
        runProgram();
        endTest();
        testBranches();
        beginTest("rerun with other ack delays");  // Random stream has moved on
        buildLoadStore();
        runProgram();
        buildAluOps();
        runProgram();
        buildLoadDirect();
        runProgram();
        endTest();
        $display("Tests run %0d, tests failed %0d, errors %0d",
            testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* dv/wbMemModel.sv */
`default_nettype none

module wbMemModel
    import cpuPkg::*;
#(
    parameter int unsigned Seed = 32'h047f_fa18
) (
    input  logic  clk,
    input  wbReqT req,
    output wbRspT rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    dataT bytes [256];
    addrT logAddr [$];  // Every write, in bus order
    dataT logData [$];

    // Responses change on the falling edge only
    initial begin
        int unsigned waitLeft;
        logic        busy;
        void'($urandom(Seed));
        rsp      = '0;
        busy     = 1'b0;
        waitLeft = 0;
        forever begin
            @(negedge clk);
            if (rsp.ack || !(req.cyc && req.stb)) begin
                rsp.ack = 1'b0;  // Ack lasts one clock edge
                busy    = 1'b0;
            end else begin
                if (!busy) begin
                    busy     = 1'b1;
                    waitLeft = $urandom_range(3, 0);
                end
                if (waitLeft == 0) begin
                    busy    = 1'b0;
                    rsp.ack = 1'b1;
                    if (req.we) begin
                        bytes[req.adr] = req.datOut;
                        logAddr.push_back(req.adr);
                        logData.push_back(req.datOut);
                    end else begin
                        rsp.datIn = bytes[req.adr];
                    end
                end else begin
                    waitLeft--;
                end
            end
        end
    end
endmodule

`default_nettype wire

/* source/addressUnit.sv */
`default_nettype none
`include "cpu_consts.svh"

module addressUnit
    import cpuPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  ctrlT ctrl,
    input  dataT memData,
    output addrT busAddr
);
    addrT pc;
    addrT mar;

    // Offset add wraps modulo 256, so two's complement needs no extension
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= `RESET_PC;
        end else if (ctrl.pcLoad) begin
            pc <= ctrl.branchAdd ? pc + addrT'(memData) : addrT'(memData);
        end else if (ctrl.pcInc) begin
            pc <= pc + addrT'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.marLoad) begin
            mar <= addrT'(memData);
        end
    end

    assign busAddr = ctrl.addrSel ? mar : pc;
endmodule

`default_nettype wire

/* source/alu.sv */
`default_nettype none
`include "cpu_consts.svh"

module alu
    import cpuPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  ctrlT  ctrl,
    input  dataT  readA,
    input  dataT  readB,
    output dataT  aluResult,
    output flagsT flags
);
    localparam int Msb = `DATA_WIDTH - 1;

    dataT                 opB;
    logic [`DATA_WIDTH:0] wide;  // Extra bit holds carry or borrow
    logic                 isSub;
    logic                 carry;
    logic                 overflow;

    always_comb begin
        isSub    = ctrl.aluOp inside {aluSub, aluDec};
        opB      = (ctrl.aluOp inside {aluInc, aluDec}) ? dataT'(1) : readB;
        wide     = isSub ? {1'b0, readA} - {1'b0, opB} : {1'b0, readA} + {1'b0, opB};
        carry    = 1'b0;
        overflow = 1'b0;
        case (ctrl.aluOp)
            aluAnd: aluResult = readA & readB;
            aluOr:  aluResult = readA | readB;
            aluXor: aluResult = readA ^ readB;
            default: begin
                aluResult = wide[Msb:0];
                carry     = wide[`DATA_WIDTH];
                if (isSub) begin
                    overflow = (readA[Msb] != opB[Msb]) && (aluResult[Msb] != readA[Msb]);
                end else begin
                    overflow = (readA[Msb] == opB[Msb]) && (aluResult[Msb] != readA[Msb]);
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            flags <= '0;
        end else if (ctrl.flagsLoad) begin
            flags <= '{n: aluResult[Msb], z: (aluResult == '0), v: overflow, c: carry};
        end
    end
endmodule

`default_nettype wire

/* source/controlFsm.sv */
`default_nettype none
`include "cpu_consts.svh"

module controlFsm
    import cpuPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  dataT   memData,
    input  flagsT  flags,
    input  logic   done,
    output busCmdT busCmd,
    output ctrlT   ctrl
);
    typedef enum logic [3:0] {
        sFetch,
        sFetchWait,
        sOpReq,
        sOpWait,
        sArgReq,
        sArgWait,
        sDataReq,
        sDataWait,
        sOffsetReq,
        sOffsetWait
    } stateT;

    localparam logic [3:0] ClassBranch = 4'(`OP_BRA >> 4);
    localparam logic [3:0] ClassTwoReg = 4'(`OP_ADD >> 4);
    localparam logic [3:0] ClassOneReg = 4'(`OP_INC >> 4);

    stateT  state;
    stateT  next;
    dataT   ir;
    regIdxT opReg;  // Register named by the first operand byte

    function automatic logic isKnown(dataT op);
        case (op)
            `OP_LDI, `OP_LDD, `OP_STD,
            `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR,
            `OP_INC, `OP_DEC,
            `OP_BRA, `OP_BCC, `OP_BCS, `OP_BNE, `OP_BEQ,
            `OP_BPL, `OP_BMI, `OP_BVC, `OP_BVS: return 1'b1;
            default: return 1'b0;  // One-byte no-op
        endcase
    endfunction

    function automatic aluOpT aluOpFor(dataT op);
        case (op)
            `OP_SUB: return aluSub;
            `OP_AND: return aluAnd;
            `OP_OR:  return aluOr;
            `OP_XOR: return aluXor;
            `OP_INC: return aluInc;
            `OP_DEC: return aluDec;
            default: return aluAdd;
        endcase
    endfunction

    function automatic logic branchTaken(dataT op, flagsT f);
        case (op)
            `OP_BRA: return 1'b1;
            `OP_BCC: return !f.c;
            `OP_BCS: return f.c;
            `OP_BNE: return !f.z;
            `OP_BEQ: return f.z;
            `OP_BPL: return !f.n;
            `OP_BMI: return f.n;
            `OP_BVC: return !f.v;
            `OP_BVS: return f.v;
            default: return 1'b0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= sFetch;
            ir    <= '0;
        end else begin
            state <= next;
            if (state == sFetchWait && done) begin
                ir <= memData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == sOpWait && done) begin
            opReg <= memData[`REG_INDEX_WIDTH-1:0];
        end
    end

    // PC advances on the edge that starts each instruction byte read
    always_comb begin
        next   = state;
        busCmd = '0;
        ctrl   = '0;
        case (state)
            sFetch: begin
                busCmd.start = 1'b1;
                ctrl.pcInc   = 1'b1;
                next         = sFetchWait;
            end
            sFetchWait: begin
                if (done) begin
                    if (!isKnown(memData)) begin
                        next = sFetch;
                    end else if (memData[7:4] == ClassBranch) begin
                        next = sOffsetReq;
                    end else begin
                        next = sOpReq;
                    end
                end
            end
            sOpReq: begin
                busCmd.start = 1'b1;
                ctrl.pcInc   = 1'b1;
                next         = sOpWait;
            end
            sOpWait: begin
                if (done) begin
                    if (ir[7:4] == ClassOneReg) begin  // INC or DEC completes here
                        ctrl.regReadIdxA = memData[`REG_INDEX_WIDTH-1:0];
                        ctrl.regWriteIdx = memData[`REG_INDEX_WIDTH-1:0];
                        ctrl.regWrite    = 1'b1;
                        ctrl.writeSrc    = srcAlu;
                        ctrl.aluOp       = aluOpFor(ir);
                        ctrl.flagsLoad   = 1'b1;
                        next             = sFetch;
                    end else begin
                        next = sArgReq;
                    end
                end
            end
            sArgReq: begin
                busCmd.start = 1'b1;
                ctrl.pcInc   = 1'b1;
                next         = sArgWait;
            end
            sArgWait: begin
                if (done) begin
                    if (ir[7:4] == ClassTwoReg) begin
                        ctrl.regReadIdxA = opReg;
                        ctrl.regReadIdxB = memData[`REG_INDEX_WIDTH-1:0];
                        ctrl.regWriteIdx = opReg;
                        ctrl.regWrite    = 1'b1;
                        ctrl.writeSrc    = srcAlu;
                        ctrl.aluOp       = aluOpFor(ir);
                        ctrl.flagsLoad   = 1'b1;
                        next             = sFetch;
                    end else if (ir == `OP_LDI) begin
                        ctrl.regWriteIdx = opReg;
                        ctrl.regWrite    = 1'b1;
                        next             = sFetch;
                    end else begin
                        ctrl.marLoad = 1'b1;  // Direct address byte
                        next         = sDataReq;
                    end
                end
            end
            sDataReq: begin
                ctrl.addrSel     = 1'b1;
                ctrl.regReadIdxA = opReg;  // Store data
                busCmd.start     = 1'b1;
                busCmd.we        = (ir == `OP_STD);
                next             = sDataWait;
            end
            sDataWait: begin
                if (done) begin
                    if (ir == `OP_LDD) begin
                        ctrl.regWriteIdx = opReg;
                        ctrl.regWrite    = 1'b1;
                    end
                    next = sFetch;
                end
            end
            sOffsetReq: begin
                busCmd.start = 1'b1;
                ctrl.pcInc   = 1'b1;
                next         = sOffsetWait;
            end
            sOffsetWait: begin
                if (done) begin
                    if (branchTaken(ir, flags)) begin
                        ctrl.pcLoad    = 1'b1;
                        ctrl.branchAdd = 1'b1;
                    end
                    next = sFetch;
                end
            end
            default: next = sFetch;
        endcase
    end

    pcUpdateExclusive: assert property (@(posedge clk) disable iff (!reset)
        !(ctrl.pcInc && ctrl.pcLoad));
endmodule

`default_nettype wire

/* source/cpuPkg.sv */
`default_nettype none
`include "cpu_consts.svh"

package cpuPkg;
    typedef logic [`DATA_WIDTH-1:0]      dataT;
    typedef logic [`ADDR_WIDTH-1:0]      addrT;
    typedef logic [`REG_INDEX_WIDTH-1:0] regIdxT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluInc,
        aluDec
    } aluOpT;

    typedef enum logic {
        srcMem,
        srcAlu
    } writeSrcT;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;  // Bit 0
    } flagsT;

    typedef struct packed {
        logic     pcInc;
        logic     pcLoad;
        logic     marLoad;
        logic     addrSel;      // Bus address from MAR instead of PC
        logic     regWrite;
        regIdxT   regWriteIdx;
        regIdxT   regReadIdxA;  // Also selects store data
        regIdxT   regReadIdxB;
        writeSrcT writeSrc;
        aluOpT    aluOp;
        logic     flagsLoad;
        logic     branchAdd;    // Relative PC load
    } ctrlT;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        addrT adr;
        dataT datOut;
    } wbReqT;

    typedef struct packed {
        logic ack;
        dataT datIn;
    } wbRspT;

    typedef struct packed {
        logic start;
        logic we;
    } busCmdT;
endpackage

`default_nettype wire

/* source/cpuTop.sv */
`default_nettype none

module cpuTop
    import cpuPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output wbReqT wbOut,
    input  wbRspT wbIn
);
    ctrlT   ctrl;
    busCmdT busCmd;
    flagsT  flags;
    addrT   busAddr;
    dataT   memData;
    dataT   readA;
    dataT   readB;
    dataT   aluResult;
    logic   done;

    controlFsm u_controlFsm (
        .clk(clk), .reset(reset), .memData(memData), .flags(flags),
        .done(done), .busCmd(busCmd), .ctrl(ctrl)
    );

    addressUnit u_addressUnit (
        .clk(clk), .reset(reset), .ctrl(ctrl), .memData(memData), .busAddr(busAddr)
    );

    regFile u_regFile (
        .clk(clk), .reset(reset), .ctrl(ctrl), .memData(memData),
        .aluResult(aluResult), .readA(readA), .readB(readB)
    );

    alu u_alu (
        .clk(clk), .reset(reset), .ctrl(ctrl), .readA(readA), .readB(readB),
        .aluResult(aluResult), .flags(flags)
    );

    wbMaster u_wbMaster (
        .clk(clk), .reset(reset), .busCmd(busCmd), .busAddr(busAddr),
        .storeData(readA),  // Register A read port doubles as store data
        .wbOut(wbOut), .wbIn(wbIn), .memData(memData), .done(done)
    );
endmodule

`default_nettype wire

/* source/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_WIDTH      8
`define ADDR_WIDTH      8
`define REG_COUNT       16
`define REG_INDEX_WIDTH 4
`define RESET_PC        8'h00

`define OP_LDI 8'h80  // LD reg, #value
`define OP_LDD 8'h81  // LD reg, [addr]
`define OP_STD 8'h82  // ST reg, [addr]
`define OP_ADD 8'h90
`define OP_SUB 8'h91
`define OP_AND 8'h92
`define OP_OR  8'h93
`define OP_XOR 8'h94
`define OP_INC 8'hA0
`define OP_DEC 8'hA1
`define OP_BRA 8'h20
`define OP_BCC 8'h21
`define OP_BCS 8'h22
`define OP_BNE 8'h23
`define OP_BEQ 8'h24
`define OP_BPL 8'h25
`define OP_BMI 8'h26
`define OP_BVC 8'h27
`define OP_BVS 8'h28

`endif

/* source/regFile.sv */
`default_nettype none
`include "cpu_consts.svh"

module regFile
    import cpuPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  ctrlT ctrl,
    input  dataT memData,
    input  dataT aluResult,
    output dataT readA,
    output dataT readB
);
    dataT regs [`REG_COUNT];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite) begin
            regs[ctrl.regWriteIdx] <= (ctrl.writeSrc == srcAlu) ? aluResult : memData;
        end
    end

    assign readA = regs[ctrl.regReadIdxA];
    assign readB = regs[ctrl.regReadIdxB];
endmodule

`default_nettype wire

/* source/wbMaster.sv */
`default_nettype none

module wbMaster
    import cpuPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  busCmdT busCmd,
    input  addrT   busAddr,
    input  dataT   storeData,
    output wbReqT  wbOut,
    input  wbRspT  wbIn,
    output dataT   memData,
    output logic   done
);
    logic cyc;
    logic stb;
    logic we;
    addrT adr;
    dataT datOut;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cyc  <= 1'b0;
            stb  <= 1'b0;
            we   <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (busCmd.start) begin
                cyc <= 1'b1;
                stb <= 1'b1;
                we  <= busCmd.we;
            end else if (stb && wbIn.ack) begin  // Cycle ends on ack
                cyc  <= 1'b0;
                stb  <= 1'b0;
                we   <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busCmd.start) begin
            adr    <= busAddr;
            datOut <= storeData;
        end
        if (stb && wbIn.ack && !we) begin
            memData <= wbIn.datIn;
        end
    end

    assign wbOut = '{cyc: cyc, stb: stb, we: we, adr: adr, datOut: datOut};

    noStartWhileBusy: assert property (@(posedge clk) disable iff (!reset)
        busCmd.start |-> !cyc);

    stbInsideCyc: assert property (@(posedge clk) disable iff (!reset)
        wbOut.stb |-> wbOut.cyc);

    // Request must hold until the slave acknowledges
    requestStable: assert property (@(posedge clk) disable iff (!reset)
        wbOut.stb && !wbIn.ack |=>
            $stable(wbOut.adr) && $stable(wbOut.we) && $stable(wbOut.datOut));
endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/cpuPkg.sv
source/controlFsm.sv
source/addressUnit.sv
source/regFile.sv
source/alu.sv
source/wbMaster.sv
source/cpuTop.sv
dv/wbMemModel.sv
dv/cpuTb.sv
